/* include/avmm_consts.svh */
/*
 * Width, memory size, queue depth and stage count constants
 * for the Avalon read/write memory subsystem
 */
`ifndef AVMM_CONSTS_SVH
`define AVMM_CONSTS_SVH

// Word address and data widths of both channels
`define AVMM_ADDR_WIDTH 16
`define AVMM_DATA_WIDTH 32

// Implemented words; any address at or above this is out of range
`define AVMM_MEM_WORDS 1024

// Depth of each request queue inside the memory
`define AVMM_QUEUE_DEPTH 8

// Default register stages and waitrequest delay of the pipeline
`define AVMM_REG_STAGES 2
`define AVMM_WAITREQ_STAGES 2

`endif

/* logic/avmm_pkg.sv */
/*
 * Request and response payload types for the split read/write Avalon link
 */
`include "avmm_consts.svh"

package avmm_pkg;

    // Avalon response codes, only the two that the memory produces
    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2
    } rsp_code_t;

    // A read request carries only the word address
    typedef struct packed {
        logic [`AVMM_ADDR_WIDTH-1:0] addr;
    } rd_req_t;

    // A write request with one enable bit per data byte
    typedef struct packed {
        logic [`AVMM_ADDR_WIDTH-1:0] addr;
        logic [`AVMM_DATA_WIDTH-1:0] data;
        logic [3:0]                  byteenable;
    } wr_req_t;

    typedef struct packed {
        logic [`AVMM_DATA_WIDTH-1:0] data;
        rsp_code_t                   resp;
    } rd_rsp_t;

    typedef struct packed {
        rsp_code_t resp;
    } wr_rsp_t;

endpackage

/* logic/avmm_pipe_stage.sv */
/*
 * Valid-qualified register chain of configurable depth for any payload type
 */
`timescale 1ns/10ps

module avmm_pipe_stage
#(
    parameter type payload_t = logic,
    parameter int  N_STAGES  = 1
)
(
    input  logic     mem_slave,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // Stage 0 is the first register after the input
    logic [N_STAGES-1:0] valid_q;
    payload_t            data_q [N_STAGES];

    // Every stage shifts each cycle, so several items can be in flight
    // and none of them ever stalls inside the chain
    always_ff @(posedge mem_slave)
    begin
        valid_q[0] <= in_valid;
        data_q[0]  <= in_data;

        for (int s = 1; s < N_STAGES; s++)
        begin
            valid_q[s] <= valid_q[s-1];
            data_q[s]  <= data_q[s-1];
        end

        // Reset empties the chain by clearing every valid bit
        if (reset)
        begin
            valid_q <= '0;
        end
    end

    // The last register drives the output directly
    assign out_valid = valid_q[N_STAGES-1];
    assign out_data  = data_q[N_STAGES-1];

endmodule

/* logic/avmm_req_fifo.sv */
/*
 * Synchronous circular-buffer FIFO for any payload type, with a fill count
 */
`timescale 1ns/10ps

module avmm_req_fifo
#(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 8
)
(
    input  logic                       mem_slave,
    input  logic                       reset,
    input  logic                       push,
    input  payload_t                   push_data,
    input  logic                       pop,
    output payload_t                   pop_data,
    output logic                       empty,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t         storage [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    // Head of the queue is visible without a pop
    assign pop_data = storage[rd_ptr];
    assign empty    = (count == '0);

    // Storage is written on every push; the slot under the read pointer
    // is only overwritten when the queue is full and popping this cycle
    always_ff @(posedge mem_slave)
    begin
        if (push)
        begin
            storage[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap at DEPTH, so any depth works, not only powers of two
    always_ff @(posedge mem_slave)
    begin
        if (push)
        begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (pop)
        begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end

        // A simultaneous push and pop leaves the fill count unchanged
        if (push && !pop)
        begin
            count <= count + 1'b1;
        end
        else if (pop && !push)
        begin
            count <= count - 1'b1;
        end

        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
    end

    // A push into a full queue must be matched by a pop in the same cycle
    a_no_overflow: assert property (@(posedge mem_slave) disable iff (reset)
        push && (count == DEPTH) |-> pop);

    a_no_underflow: assert property (@(posedge mem_slave) disable iff (reset)
        pop |-> !empty);

endmodule

/* logic/avmm_rdwr_reg_pipe.sv */
/*
 * Register pipeline for a split read/write Avalon link, with waitrequest
 * delay lines that turn waitrequest into an almost-full signal
 */
`timescale 1ns/10ps
`include "avmm_consts.svh"

module avmm_rdwr_reg_pipe
#(
    parameter int N_REG_STAGES         = `AVMM_REG_STAGES,
    parameter int N_WAITREQUEST_STAGES = `AVMM_WAITREQ_STAGES
)
(
    input  logic                        mem_slave,
    input  logic                        reset,

    // Master side, read group
    input  logic                        m_rd_read,
    input  logic [`AVMM_ADDR_WIDTH-1:0] m_rd_address,
    output logic                        m_rd_waitrequest,
    output logic                        m_rd_readdatavalid,
    output logic [`AVMM_DATA_WIDTH-1:0] m_rd_readdata,
    output avmm_pkg::rsp_code_t         m_rd_response,

    // Master side, write group
    input  logic                        m_wr_write,
    input  logic [`AVMM_ADDR_WIDTH-1:0] m_wr_address,
    input  logic [`AVMM_DATA_WIDTH-1:0] m_wr_writedata,
    input  logic [3:0]                  m_wr_byteenable,
    output logic                        m_wr_waitrequest,
    output logic                        m_wr_writeresponsevalid,
    output avmm_pkg::rsp_code_t         m_wr_response,

    // Slave side, read group
    output logic                        s_rd_read,
    output logic [`AVMM_ADDR_WIDTH-1:0] s_rd_address,
    input  logic                        s_rd_waitrequest,
    input  logic                        s_rd_readdatavalid,
    input  logic [`AVMM_DATA_WIDTH-1:0] s_rd_readdata,
    input  avmm_pkg::rsp_code_t         s_rd_response,

    // Slave side, write group
    output logic                        s_wr_write,
    output logic [`AVMM_ADDR_WIDTH-1:0] s_wr_address,
    output logic [`AVMM_DATA_WIDTH-1:0] s_wr_writedata,
    output logic [3:0]                  s_wr_byteenable,
    input  logic                        s_wr_waitrequest,
    input  logic                        s_wr_writeresponsevalid,
    input  avmm_pkg::rsp_code_t         s_wr_response
);

    import avmm_pkg::*;

    if (N_REG_STAGES == 0)
    begin : wires
        // No stages, so the slave sees the master's requests unchanged
        assign s_rd_read               = m_rd_read;
        assign s_rd_address            = m_rd_address;
        assign m_rd_waitrequest        = s_rd_waitrequest;
        assign m_rd_readdatavalid      = s_rd_readdatavalid;
        assign m_rd_readdata           = s_rd_readdata;
        assign m_rd_response           = s_rd_response;
        assign s_wr_write              = m_wr_write;
        assign s_wr_address            = m_wr_address;
        assign s_wr_writedata          = m_wr_writedata;
        assign s_wr_byteenable         = m_wr_byteenable;
        assign m_wr_waitrequest        = s_wr_waitrequest;
        assign m_wr_writeresponsevalid = s_wr_writeresponsevalid;
        assign m_wr_response           = s_wr_response;
    end
    else
    begin : regs
        rd_req_t m_rd_req;
        rd_req_t s_rd_req;
        wr_req_t m_wr_req;
        wr_req_t s_wr_req;
        rd_rsp_t s_rd_rsp;
        rd_rsp_t m_rd_rsp;
        wr_rsp_t s_wr_rsp;
        wr_rsp_t m_wr_rsp;
        logic    m_rd_accept;
        logic    m_wr_accept;

        // Bit 0 is the slave's waitrequest, the top bit goes to the master
        logic [N_WAITREQUEST_STAGES:0] rd_wait_pipe;
        logic [N_WAITREQUEST_STAGES:0] wr_wait_pipe;

        assign rd_wait_pipe[0] = s_rd_waitrequest;
        assign wr_wait_pipe[0] = s_wr_waitrequest;

        // Shift registers start at ones, which holds the master off
        // until the slave's state has propagated through the delay line
        if (N_WAITREQUEST_STAGES > 0)
        begin : wait_dly
            always_ff @(posedge mem_slave)
            begin
                rd_wait_pipe[N_WAITREQUEST_STAGES:1] <= reset ? '1 :
                    rd_wait_pipe[N_WAITREQUEST_STAGES-1:0];
                wr_wait_pipe[N_WAITREQUEST_STAGES:1] <= reset ? '1 :
                    wr_wait_pipe[N_WAITREQUEST_STAGES-1:0];
            end
        end

        assign m_rd_waitrequest = rd_wait_pipe[N_WAITREQUEST_STAGES];
        assign m_wr_waitrequest = wr_wait_pipe[N_WAITREQUEST_STAGES];

        // A request enters the chain only in the cycle the master sees it accepted
        assign m_rd_accept = m_rd_read && !m_rd_waitrequest;
        assign m_wr_accept = m_wr_write && !m_wr_waitrequest;

        assign m_rd_req = '{addr: m_rd_address};
        assign m_wr_req = '{addr: m_wr_address, data: m_wr_writedata,
                            byteenable: m_wr_byteenable};
        assign s_rd_rsp = '{data: s_rd_readdata, resp: s_rd_response};
        assign s_wr_rsp = '{resp: s_wr_response};

        avmm_pipe_stage #(.payload_t(rd_req_t), .N_STAGES(N_REG_STAGES)) u_rd_req
        (
            .mem_slave (mem_slave),
            .reset     (reset),
            .in_valid  (m_rd_accept),
            .in_data   (m_rd_req),
            .out_valid (s_rd_read),
            .out_data  (s_rd_req)
        );

        avmm_pipe_stage #(.payload_t(wr_req_t), .N_STAGES(N_REG_STAGES)) u_wr_req
        (
            .mem_slave (mem_slave),
            .reset     (reset),
            .in_valid  (m_wr_accept),
            .in_data   (m_wr_req),
            .out_valid (s_wr_write),
            .out_data  (s_wr_req)
        );

        // Responses cannot be back-pressured, so the chains run freely
        avmm_pipe_stage #(.payload_t(rd_rsp_t), .N_STAGES(N_REG_STAGES)) u_rd_rsp
        (
            .mem_slave (mem_slave),
            .reset     (reset),
            .in_valid  (s_rd_readdatavalid),
            .in_data   (s_rd_rsp),
            .out_valid (m_rd_readdatavalid),
            .out_data  (m_rd_rsp)
        );

        avmm_pipe_stage #(.payload_t(wr_rsp_t), .N_STAGES(N_REG_STAGES)) u_wr_rsp
        (
            .mem_slave (mem_slave),
            .reset     (reset),
            .in_valid  (s_wr_writeresponsevalid),
            .in_data   (s_wr_rsp),
            .out_valid (m_wr_writeresponsevalid),
            .out_data  (m_wr_rsp)
        );

        assign s_rd_address    = s_rd_req.addr;
        assign s_wr_address    = s_wr_req.addr;
        assign s_wr_writedata  = s_wr_req.data;
        assign s_wr_byteenable = s_wr_req.byteenable;
        assign m_rd_readdata   = m_rd_rsp.data;
        assign m_rd_response   = m_rd_rsp.resp;
        assign m_wr_response   = m_wr_rsp.resp;

        // Stale stage contents must not reach the slave once reset is released
        a_req_idle_after_reset: assert property (@(posedge mem_slave)
            reset |=> !s_rd_read && !s_wr_write);
    end

endmodule

/* logic/avmm_rdwr_mem.sv */
/*
 * Word memory slave with request queues, address range check and
 * in-order responses on separate read and write channels
 */
`timescale 1ns/10ps
`include "avmm_consts.svh"

module avmm_rdwr_mem
#(
    parameter int WAIT_ALLOWANCE = `AVMM_WAITREQ_STAGES + `AVMM_REG_STAGES
)
(
    input  logic                        mem_slave,
    input  logic                        reset,

    input  logic                        rd_read,
    input  logic [`AVMM_ADDR_WIDTH-1:0] rd_address,
    output logic                        rd_waitrequest,
    output logic                        rd_readdatavalid,
    output logic [`AVMM_DATA_WIDTH-1:0] rd_readdata,
    output avmm_pkg::rsp_code_t         rd_response,

    input  logic                        wr_write,
    input  logic [`AVMM_ADDR_WIDTH-1:0] wr_address,
    input  logic [`AVMM_DATA_WIDTH-1:0] wr_writedata,
    input  logic [3:0]                  wr_byteenable,
    output logic                        wr_waitrequest,
    output logic                        wr_writeresponsevalid,
    output avmm_pkg::rsp_code_t         wr_response
);

    import avmm_pkg::*;

    localparam int IDX_W = $clog2(`AVMM_MEM_WORDS);
    localparam int CNT_W = $clog2(`AVMM_QUEUE_DEPTH + 1);

    rd_req_t                     rd_head;
    wr_req_t                     wr_head;
    logic                        rd_empty;
    logic                        wr_empty;
    logic [CNT_W-1:0]            rd_count;
    logic [CNT_W-1:0]            wr_count;
    logic                        rd_pop;
    logic                        wr_pop;
    logic                        rd_in_range;
    logic                        wr_in_range;
    logic [`AVMM_DATA_WIDTH-1:0] mem_array [`AVMM_MEM_WORDS];

    avmm_req_fifo #(.payload_t(rd_req_t), .DEPTH(`AVMM_QUEUE_DEPTH)) u_rd_queue
    (
        .mem_slave (mem_slave),
        .reset     (reset),
        .push      (rd_read),
        .push_data ('{addr: rd_address}),
        .pop       (rd_pop),
        .pop_data  (rd_head),
        .empty     (rd_empty),
        .count     (rd_count)
    );

    avmm_req_fifo #(.payload_t(wr_req_t), .DEPTH(`AVMM_QUEUE_DEPTH)) u_wr_queue
    (
        .mem_slave (mem_slave),
        .reset     (reset),
        .push      (wr_write),
        .push_data ('{addr: wr_address, data: wr_writedata, byteenable: wr_byteenable}),
        .pop       (wr_pop),
        .pop_data  (wr_head),
        .empty     (wr_empty),
        .count     (wr_count)
    );

    // Leave room for the requests still in flight when waitrequest rises
    assign rd_waitrequest = (rd_count >= CNT_W'(`AVMM_QUEUE_DEPTH - WAIT_ALLOWANCE));
    assign wr_waitrequest = (wr_count >= CNT_W'(`AVMM_QUEUE_DEPTH - WAIT_ALLOWANCE));

    // The head of each queue is served in every cycle it exists
    assign rd_pop      = !rd_empty;
    assign wr_pop      = !wr_empty;
    assign rd_in_range = (rd_head.addr < `AVMM_MEM_WORDS);
    assign wr_in_range = (wr_head.addr < `AVMM_MEM_WORDS);

    // A write merges its data under the byte enables
    // An out-of-range write leaves the array untouched.
    // A read served in the same cycle as a write to its word sees the old data
    always_ff @(posedge mem_slave)
    begin
        if (wr_pop && wr_in_range)
        begin
            for (int b = 0; b < $bits(wr_head.byteenable); b++)
            begin
                if (wr_head.byteenable[b])
                begin
                    mem_array[wr_head.addr[IDX_W-1:0]][8*b +: 8] <= wr_head.data[8*b +: 8];
                end
            end
        end
    end

    // Responses leave one cycle after their request is served
    always_ff @(posedge mem_slave)
    begin
        rd_readdatavalid      <= rd_pop;
        wr_writeresponsevalid <= wr_pop;

        if (rd_pop)
        begin
            rd_readdata <= rd_in_range ? mem_array[rd_head.addr[IDX_W-1:0]] : '0;
            rd_response <= rd_in_range ? OKAY : SLVERR;
        end
        if (wr_pop)
        begin
            wr_response <= wr_in_range ? OKAY : SLVERR;
        end

        if (reset)
        begin
            rd_readdatavalid      <= 1'b0;
            wr_writeresponsevalid <= 1'b0;
        end
    end

    // The upstream pipeline must keep within the waitrequest allowance
    a_rd_allowance: assert property (@(posedge mem_slave) disable iff (reset)
        rd_read |-> rd_count < CNT_W'(`AVMM_QUEUE_DEPTH));

    a_wr_allowance: assert property (@(posedge mem_slave) disable iff (reset)
        wr_write |-> wr_count < CNT_W'(`AVMM_QUEUE_DEPTH));

endmodule

/* logic/avmm_mem_subsys.sv */
/*
 * Top level that places the register pipeline in front of the memory slave
 */
`timescale 1ns/10ps
`include "avmm_consts.svh"

module avmm_mem_subsys
(
    input  logic                        mem_slave,
    input  logic                        reset,

    input  logic                        rd_read,
    input  logic [`AVMM_ADDR_WIDTH-1:0] rd_address,
    output logic                        rd_waitrequest,
    output logic                        rd_readdatavalid,
    output logic [`AVMM_DATA_WIDTH-1:0] rd_readdata,
    output avmm_pkg::rsp_code_t         rd_response,

    input  logic                        wr_write,
    input  logic [`AVMM_ADDR_WIDTH-1:0] wr_address,
    input  logic [`AVMM_DATA_WIDTH-1:0] wr_writedata,
    input  logic [3:0]                  wr_byteenable,
    output logic                        wr_waitrequest,
    output logic                        wr_writeresponsevalid,
    output avmm_pkg::rsp_code_t         wr_response
);

    import avmm_pkg::*;

    // Link between the pipeline's slave side and the memory
    logic                        mem_rd_read;
    logic [`AVMM_ADDR_WIDTH-1:0] mem_rd_address;
    logic                        mem_rd_waitrequest;
    logic                        mem_rd_readdatavalid;
    logic [`AVMM_DATA_WIDTH-1:0] mem_rd_readdata;
    rsp_code_t                   mem_rd_response;
    logic                        mem_wr_write;
    logic [`AVMM_ADDR_WIDTH-1:0] mem_wr_address;
    logic [`AVMM_DATA_WIDTH-1:0] mem_wr_writedata;
    logic [3:0]                  mem_wr_byteenable;
    logic                        mem_wr_waitrequest;
    logic                        mem_wr_writeresponsevalid;
    rsp_code_t                   mem_wr_response;

    avmm_rdwr_reg_pipe
    #(
        .N_REG_STAGES         (`AVMM_REG_STAGES),
        .N_WAITREQUEST_STAGES (`AVMM_WAITREQ_STAGES)
    )
    u_pipe
    (
        .mem_slave               (mem_slave),
        .reset                   (reset),
        .m_rd_read               (rd_read),
        .m_rd_address            (rd_address),
        .m_rd_waitrequest        (rd_waitrequest),
        .m_rd_readdatavalid      (rd_readdatavalid),
        .m_rd_readdata           (rd_readdata),
        .m_rd_response           (rd_response),
        .m_wr_write              (wr_write),
        .m_wr_address            (wr_address),
        .m_wr_writedata          (wr_writedata),
        .m_wr_byteenable         (wr_byteenable),
        .m_wr_waitrequest        (wr_waitrequest),
        .m_wr_writeresponsevalid (wr_writeresponsevalid),
        .m_wr_response           (wr_response),
        .s_rd_read               (mem_rd_read),
        .s_rd_address            (mem_rd_address),
        .s_rd_waitrequest        (mem_rd_waitrequest),
        .s_rd_readdatavalid      (mem_rd_readdatavalid),
        .s_rd_readdata           (mem_rd_readdata),
        .s_rd_response           (mem_rd_response),
        .s_wr_write              (mem_wr_write),
        .s_wr_address            (mem_wr_address),
        .s_wr_writedata          (mem_wr_writedata),
        .s_wr_byteenable         (mem_wr_byteenable),
        .s_wr_waitrequest        (mem_wr_waitrequest),
        .s_wr_writeresponsevalid (mem_wr_writeresponsevalid),
        .s_wr_response           (mem_wr_response)
    );

    // The memory must absorb everything in the delay line and the stages
    avmm_rdwr_mem #(.WAIT_ALLOWANCE(`AVMM_WAITREQ_STAGES + `AVMM_REG_STAGES)) u_mem
    (
        .mem_slave             (mem_slave),
        .reset                 (reset),
        .rd_read               (mem_rd_read),
        .rd_address            (mem_rd_address),
        .rd_waitrequest        (mem_rd_waitrequest),
        .rd_readdatavalid      (mem_rd_readdatavalid),
        .rd_readdata           (mem_rd_readdata),
        .rd_response           (mem_rd_response),
        .wr_write              (mem_wr_write),
        .wr_address            (mem_wr_address),
        .wr_writedata          (mem_wr_writedata),
        .wr_byteenable         (mem_wr_byteenable),
        .wr_waitrequest        (mem_wr_waitrequest),
        .wr_writeresponsevalid (mem_wr_writeresponsevalid),
        .wr_response           (mem_wr_response)
    );

endmodule

/* bench/avmm_mem_subsys_tb.sv */
/*
 * Testbench for the Avalon memory subsystem: clock, reset, stimulus,
 * shadow-memory reference model, response compare process and report
 */
`timescale 1ns/10ps
`include "avmm_consts.svh"

module avmm_mem_subsys_tb;

    import avmm_pkg::*;

    localparam int AW           = `AVMM_ADDR_WIDTH;
    localparam int DW           = `AVMM_DATA_WIDTH;
    localparam int ADDR_SPAN    = 1 << AW;
    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT   = 100;
    localparam int DRAIN_LIMIT  = 200;
    localparam int WR_COUNT     = 16;
    localparam int BP_COUNT     = 32;

    logic            mem_slave;
    logic            reset;
    logic            rd_read;
    logic [AW-1:0]   rd_address;
    logic            rd_waitrequest;
    logic            rd_readdatavalid;
    logic [DW-1:0]   rd_readdata;
    rsp_code_t       rd_response;
    logic            wr_write;
    logic [AW-1:0]   wr_address;
    logic [DW-1:0]   wr_writedata;
    logic [3:0]      wr_byteenable;
    logic            wr_waitrequest;
    logic            wr_writeresponsevalid;
    rsp_code_t       wr_response;

    // Shadow copy of the memory and the responses still owed by the DUT
    logic [DW-1:0]   shadow_mem [`AVMM_MEM_WORDS];
    rd_rsp_t         rd_exp_q [$];
    wr_rsp_t         wr_exp_q [$];

    logic [31:0]     rng_state = 32'hf9c48b11;
    string           test_name = "none";
    int              error_count;
    int              check_count;
    int              test_count;
    int              failed_tests;
    int              errors_at_start;
    logic [AW-1:0]   wr_addrs [WR_COUNT];
    logic [AW-1:0]   bp_rd_addr [BP_COUNT];
    logic [AW-1:0]   bp_wr_addr [BP_COUNT];
    logic [DW-1:0]   bp_wr_data [BP_COUNT];
    logic [3:0]      bp_wr_be [BP_COUNT];

    avmm_mem_subsys u_dut
    (
        .mem_slave             (mem_slave),
        .reset                 (reset),
        .rd_read               (rd_read),
        .rd_address            (rd_address),
        .rd_waitrequest        (rd_waitrequest),
        .rd_readdatavalid      (rd_readdatavalid),
        .rd_readdata           (rd_readdata),
        .rd_response           (rd_response),
        .wr_write              (wr_write),
        .wr_address            (wr_address),
        .wr_writedata          (wr_writedata),
        .wr_byteenable         (wr_byteenable),
        .wr_waitrequest        (wr_waitrequest),
        .wr_writeresponsevalid (wr_writeresponsevalid),
        .wr_response           (wr_response)
    );

    // 10 ns clock period
    always
    begin
        #5 mem_slave = 1'b1;
        #5 mem_slave = 1'b0;
    end

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Expected read result from the range rule and the shadow memory
    function automatic rd_rsp_t model_read(input logic [AW-1:0] addr);
        rd_rsp_t rsp;
        if (addr < `AVMM_MEM_WORDS)
        begin
            rsp.data = shadow_mem[addr];
            rsp.resp = OKAY;
        end
        else
        begin
            rsp.data = '0;
            rsp.resp = SLVERR;
        end
        return rsp;
    endfunction

    // Merges enabled bytes into the shadow word; out of range changes nothing
    function automatic wr_rsp_t model_write(input logic [AW-1:0] addr,
                                            input logic [DW-1:0] data,
                                            input logic [3:0] be);
        wr_rsp_t rsp;
        rsp.resp = SLVERR;
        if (addr < `AVMM_MEM_WORDS)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (be[b])
                begin
                    shadow_mem[addr][8*b +: 8] = data[8*b +: 8];
                end
            end
            rsp.resp = OKAY;
        end
        return rsp;
    endfunction

    task automatic check_rd_rsp(input rd_rsp_t exp, input rd_rsp_t act);
        check_count++;
        if (act !== exp)
        begin
            error_count++;
            $display("ERROR %s: read expected data %h resp %0d, actual data %h resp %0d",
                     test_name, exp.data, exp.resp, act.data, act.resp);
        end
    endtask

    task automatic check_wr_rsp(input wr_rsp_t exp, input wr_rsp_t act);
        check_count++;
        if (act !== exp)
        begin
            error_count++;
            $display("ERROR %s: write expected resp %0d, actual resp %0d",
                     test_name, exp.resp, act.resp);
        end
    endtask

    task automatic expect_level(input string what, input logic exp, input logic act);
        check_count++;
        if (act !== exp)
        begin
            error_count++;
            $display("ERROR %s: %s expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    // Both waitrequests held high and no response of either kind
    task automatic idle_levels();
        expect_level("rd_waitrequest", 1'b1, rd_waitrequest);
        expect_level("wr_waitrequest", 1'b1, wr_waitrequest);
        expect_level("rd_readdatavalid", 1'b0, rd_readdatavalid);
        expect_level("wr_writeresponsevalid", 1'b0, wr_writeresponsevalid);
    endtask

    task automatic abort_run(input string why);
        $display("Test %s stopped: %s", test_name, why);
        $display("TB FAILED");
        $finish;
    endtask

    // Called 1 ns after a rising edge; returns 1 ns after the accepting edge
    task automatic issue_read(input logic [AW-1:0] addr);
        int waited;
        waited     = 0;
        rd_read    = 1'b1;
        rd_address = addr;
        @(negedge mem_slave);
        while (rd_waitrequest !== 1'b0 && waited < WAIT_LIMIT)
        begin
            @(negedge mem_slave);
            waited++;
        end
        if (rd_waitrequest !== 1'b0)
        begin
            abort_run("read request was never accepted");
        end
        rd_exp_q.push_back(model_read(addr));
        @(posedge mem_slave);
        #1;
        rd_read = 1'b0;
    endtask

    task automatic issue_write(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                               input logic [3:0] be);
        int waited;
        waited        = 0;
        wr_write      = 1'b1;
        wr_address    = addr;
        wr_writedata  = data;
        wr_byteenable = be;
        @(negedge mem_slave);
        while (wr_waitrequest !== 1'b0 && waited < WAIT_LIMIT)
        begin
            @(negedge mem_slave);
            waited++;
        end
        if (wr_waitrequest !== 1'b0)
        begin
            abort_run("write request was never accepted");
        end
        wr_exp_q.push_back(model_write(addr, data, be));
        @(posedge mem_slave);
        #1;
        wr_write = 1'b0;
    endtask

    // Waits until every issued request has had its response
    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((rd_exp_q.size() != 0 || wr_exp_q.size() != 0) && waited < DRAIN_LIMIT)
        begin
            @(negedge mem_slave);
            waited++;
        end
        if (rd_exp_q.size() != 0 || wr_exp_q.size() != 0)
        begin
            abort_run("responses are missing after the drain timeout");
        end
        @(posedge mem_slave);
        #1;
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        int errs;
        wait_drain();
        errs = error_count - errors_at_start;
        test_count++;
        if (errs != 0)
        begin
            failed_tests++;
        end
        $display("test %s %s, %0d errors", test_name, (errs == 0) ? "ok" : "bad", errs);
    endtask

    // Responses are sampled on the falling edge, halfway between updates
    always @(negedge mem_slave)
    begin
        rd_rsp_t exp_rd;
        rd_rsp_t act_rd;
        wr_rsp_t exp_wr;
        wr_rsp_t act_wr;
        if (!reset && rd_readdatavalid === 1'b1)
        begin
            if (rd_exp_q.size() == 0)
            begin
                error_count++;
                $display("Test %s: read response arrived with no read outstanding", test_name);
            end
            else
            begin
                exp_rd      = rd_exp_q.pop_front();
                act_rd.data = rd_readdata;
                act_rd.resp = rd_response;
                check_rd_rsp(exp_rd, act_rd);
            end
        end
        if (!reset && wr_writeresponsevalid === 1'b1)
        begin
            if (wr_exp_q.size() == 0)
            begin
                error_count++;
                $display("Test %s: write response arrived with no write outstanding", test_name);
            end
            else
            begin
                exp_wr      = wr_exp_q.pop_front();
                act_wr.resp = wr_response;
                check_wr_rsp(exp_wr, act_wr);
            end
        end
    end

    initial
    begin
        mem_slave     = 1'b0;
        reset         = 1'b1;
        rd_read       = 1'b0;
        rd_address    = '0;
        wr_write      = 1'b0;
        wr_address    = '0;
        wr_writedata  = '0;
        wr_byteenable = '0;

        // Reset state, checked during reset and in the two cycles after it
        start_test("reset_state");
        for (int c = 0; c < RESET_CYCLES - 1; c++)
        begin
            @(negedge mem_slave);
            idle_levels();
        end
        @(posedge mem_slave);
        #1;
        reset = 1'b0;
        repeat (2)
        begin
            @(negedge mem_slave);
            idle_levels();
        end
        @(posedge mem_slave);
        #1;
        end_test();

        // Full-word writes in the low quarter, then read back
        start_test("write_read");
        for (int i = 0; i < WR_COUNT; i++)
        begin
            wr_addrs[i] = AW'(xorshift() % 256);
            issue_write(wr_addrs[i], xorshift(), 4'hf);
        end
        wait_drain();
        for (int i = 0; i < WR_COUNT; i++)
        begin
            issue_read(wr_addrs[i]);
        end
        end_test();

        // Partial writes over a known word
        start_test("byte_merge");
        issue_write(AW'(300), 32'h11223344, 4'hf);
        issue_write(AW'(300), 32'haabbccdd, 4'b0001);
        issue_write(AW'(300), 32'h55667788, 4'b0110);
        issue_write(AW'(300), 32'h99000000, 4'b1000);
        wait_drain();
        issue_read(AW'(300));
        end_test();

        // The aliased write must leave the in-range word untouched
        start_test("out_of_range");
        issue_write(AW'(`AVMM_MEM_WORDS), xorshift(), 4'hf);
        issue_write(AW'(ADDR_SPAN - 1), xorshift(), 4'hf);
        issue_write(AW'(`AVMM_MEM_WORDS) + wr_addrs[0], xorshift(), 4'hf);
        wait_drain();
        issue_read(AW'(`AVMM_MEM_WORDS));
        issue_read(AW'(ADDR_SPAN - 1));
        issue_read(AW'(`AVMM_MEM_WORDS + xorshift() % (ADDR_SPAN - `AVMM_MEM_WORDS)));
        issue_read(wr_addrs[0]);
        end_test();

        // Reads hit stable words only, writes go to the untouched upper half
        start_test("back_pressure");
        for (int i = 0; i < BP_COUNT; i++)
        begin
            if (i % 8 == 7)
            begin
                bp_rd_addr[i] = AW'(`AVMM_MEM_WORDS + xorshift() % 4096);
            end
            else
            begin
                bp_rd_addr[i] = wr_addrs[xorshift() % WR_COUNT];
            end
            bp_wr_addr[i] = AW'(512 + xorshift() % 512);
            bp_wr_data[i] = xorshift();
            bp_wr_be[i]   = 4'(xorshift());
        end
        fork
            begin
                for (int i = 0; i < BP_COUNT; i++)
                begin
                    issue_read(bp_rd_addr[i]);
                end
            end
            begin
                for (int i = 0; i < BP_COUNT; i++)
                begin
                    issue_write(bp_wr_addr[i], bp_wr_data[i], bp_wr_be[i]);
                end
            end
        join
        end_test();

        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count != 0)
        begin
            $display("TB FAILED");
        end
        else
        begin
            $display("TB PASSED");
        end
        $finish;
    end

endmodule

/* avmm_mem_subsys.f */
+incdir+include
logic/avmm_pkg.sv
logic/avmm_pipe_stage.sv
logic/avmm_req_fifo.sv
logic/avmm_rdwr_reg_pipe.sv
logic/avmm_rdwr_mem.sv
logic/avmm_mem_subsys.sv
bench/avmm_mem_subsys_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f avmm_mem_subsys.f \
    --top-module avmm_mem_subsys_tb \
    -o avmm_mem_subsys_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/avmm_mem_subsys_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The testbench prints its failure line on any failed check or timeout
if grep -q "TB FAILED" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
